/* verilog.f */
rtl/matrix_pkg.sv
rtl/matrix_order.sv
rtl/row_adder.sv
rtl/matrix_restore.sv
rtl/matrix_adder.sv
tests/matrix_adder_tb.sv

/* run.sh */
#!/bin/sh
# build and run the matrix adder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module matrix_adder_tb \
    -f verilog.f \
    -o matrix_adder_sim

./obj_dir/matrix_adder_sim

/* tests/matrix_adder_tb.sv */
`timescale 1ns/1ps

module matrix_adder_tb;
    import matrix_pkg::*;

    localparam int num_ops = 32;
    localparam int timeout_cycles = 30 * num_ops + 50;
    localparam int op_latency = 8;

    logic    clk;
    logic    reset_n;
    logic    en;
    dim_t    r1;
    dim_t    c1;
    dim_t    r2;
    dim_t    c2;
    matrix_t data1_in;
    matrix_t data2_in;
    dim_t    r_out;
    dim_t    c_out;
    matrix_t data_out;
    logic    valid;
    logic    busy;

    // expected values handed to the compare process
    matrix_t exp_data;
    dim_t    exp_r;
    dim_t    exp_c;
    logic    exp_valid;
    logic    exp_busy;
    bit      exp_timed;
    int      measured_edges;
    event    compare_ev;

    logic [31:0] rng_state;
    int          cycle_count;

    matrix_adder matrix_adder_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .en       (en),
        .r1       (r1),
        .c1       (c1),
        .r2       (r2),
        .c2       (c2),
        .data1_in (data1_in),
        .data2_in (data2_in),
        .r_out    (r_out),
        .c_out    (c_out),
        .data_out (data_out),
        .valid    (valid),
        .busy     (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= timeout_cycles) begin
                $display("Verification failed");
                $fatal(1, "timeout: tests did not finish within %0d cycles", timeout_cycles);
            end
        end
    end

    // linear congruential generator keeping the upper half
    function automatic logic [15:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[31:16];
    endfunction

    function automatic dim_t rand_dim();
        return dim_t'(next_rand() % 16'd5 + 16'd1);
    endfunction

    function automatic matrix_t rand_matrix(input bit near_max);
        matrix_t m;
        for (int k = 0; k < grid_size; k++) begin
            if (near_max) begin
                m.elem[5'(k)] = elem_t'(16'd500 + next_rand() % 16'd12);
            end else begin
                m.elem[5'(k)] = elem_t'(next_rand());
            end
        end
        return m;
    endfunction

    // element-wise sum of the first rows*cols slots wrapping at 512
    function automatic matrix_t ref_add(input matrix_t a, input matrix_t b,
                                        input dim_t rows, input dim_t cols);
        matrix_t result;
        int      count;
        result = '0;
        count = int'(rows) * int'(cols);
        for (int k = 0; k < grid_size; k++) begin
            if (k < count) begin
                result.elem[5'(k)] = a.elem[5'(k)] + b.elem[5'(k)];
            end
        end
        return result;
    endfunction

    task automatic check_matrix(input string name, input matrix_t expected, input matrix_t actual);
        if (actual !== expected) begin
            $display("Error at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_dim(input string name, input dim_t expected, input dim_t actual);
        if (actual !== expected) begin
            $display("Error at %0t: %s expected %0d, actual %0d", $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Error at %0t: %s expected %b, actual %b", $time, name, expected, actual);
            $display("Verification failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // compare process
    initial begin
        forever begin
            @(compare_ev);
            check_matrix("data_out", exp_data, data_out);
            check_dim("r_out", exp_r, r_out);
            check_dim("c_out", exp_c, c_out);
            check_flag("valid", exp_valid, valid);
            check_flag("busy", exp_busy, busy);
            if (exp_timed && measured_edges != op_latency) begin
                $display("Verification failed");
                $fatal(1, "busy fell %0d edges after start instead of %0d",
                       measured_edges, op_latency);
            end
        end
    end

    task automatic post_expect(input matrix_t d, input dim_t r, input dim_t c,
                               input logic v, input logic b, input bit timed, input int edges);
        exp_data       = d;
        exp_r          = r;
        exp_c          = c;
        exp_valid      = v;
        exp_busy       = b;
        exp_timed      = timed;
        measured_edges = edges;
        -> compare_ev;
    endtask

    task automatic drive_inputs(input matrix_t a, input matrix_t b, input dim_t ra,
                                input dim_t ca, input dim_t rb, input dim_t cb);
        r1       = ra;
        c1       = ca;
        r2       = rb;
        c2       = cb;
        data1_in = a;
        data2_in = b;
        en       = 1'b1;
    endtask

    // drop en and expect idle outputs one edge later
    task automatic release_en();
        en       = 1'b0;
        r1       = '0;
        c1       = '0;
        r2       = '0;
        c2       = '0;
        data1_in = '0;
        data2_in = '0;
        @(negedge clk);
        post_expect('0, '0, '0, 1'b1, 1'b0, 1'b0, 0);
    endtask

    task automatic run_op(input matrix_t a, input matrix_t b, input dim_t r, input dim_t c);
        int      edges;
        matrix_t expected;
        expected = ref_add(a, b, r, c);
        drive_inputs(a, b, r, c, r, c);
        @(posedge clk);
        edges = 0;
        @(negedge clk);
        while (busy) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        post_expect(expected, r, c, 1'b1, 1'b0, 1'b1, edges);
        // result must hold while en stays high
        repeat (3) @(negedge clk);
        post_expect(expected, r, c, 1'b1, 1'b0, 1'b0, 0);
        @(negedge clk);
        release_en();
    endtask

    task automatic reject_op(input dim_t ra, input dim_t ca, input dim_t rb, input dim_t cb);
        drive_inputs(rand_matrix(1'b0), rand_matrix(1'b0), ra, ca, rb, cb);
        repeat (4) @(negedge clk);
        post_expect('0, '0, '0, 1'b0, 1'b0, 1'b0, 0);
        @(negedge clk);
        release_en();
    endtask

    task automatic abort_op(input dim_t r, input dim_t c);
        drive_inputs(rand_matrix(1'b0), rand_matrix(1'b0), r, c, r, c);
        repeat (4) @(negedge clk);
        post_expect('0, r, c, 1'b1, 1'b1, 1'b0, 0);
        @(negedge clk);
        release_en();
    endtask

    initial begin
        dim_t r;
        dim_t c;
        rng_state = 32'd77;
        reset_n   = 1'b0;
        en        = 1'b0;
        r1        = '0;
        c1        = '0;
        r2        = '0;
        c2        = '0;
        data1_in  = '0;
        data2_in  = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        post_expect('0, '0, '0, 1'b1, 1'b0, 1'b0, 0);
        @(negedge clk);

        for (int i = 0; i < 20; i++) begin
            r = rand_dim();
            c = rand_dim();
            run_op(rand_matrix(1'b0), rand_matrix(1'b0), r, c);
        end

        run_op(rand_matrix(1'b1), rand_matrix(1'b1), 3'd5, 3'd5);

        run_op(rand_matrix(1'b0), rand_matrix(1'b0), 3'd1, 3'd5);
        run_op(rand_matrix(1'b0), rand_matrix(1'b0), 3'd5, 3'd1);
        run_op(rand_matrix(1'b0), rand_matrix(1'b0), 3'd1, 3'd1);

        reject_op(3'd3, 3'd4, 3'd4, 3'd3);
        reject_op(3'd0, 3'd3, 3'd0, 3'd3);
        reject_op(3'd6, 3'd2, 3'd6, 3'd2);
        reject_op(3'd2, 3'd7, 3'd2, 3'd7);

        // clear after a result and then mid-operation
        run_op(rand_matrix(1'b0), rand_matrix(1'b0), 3'd4, 3'd3);
        run_op(rand_matrix(1'b0), rand_matrix(1'b0), 3'd2, 3'd5);
        abort_op(3'd5, 3'd4);
        run_op(rand_matrix(1'b0), rand_matrix(1'b0), 3'd3, 3'd3);

        @(negedge clk);
        $display("Verification passed");
        $finish;
    end

endmodule

/* rtl/matrix_adder.sv */
`timescale 1ns/1ps

module matrix_adder (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                en,
    input  matrix_pkg::dim_t    r1,
    input  matrix_pkg::dim_t    c1,
    input  matrix_pkg::dim_t    r2,
    input  matrix_pkg::dim_t    c2,
    input  matrix_pkg::matrix_t data1_in,
    input  matrix_pkg::matrix_t data2_in,
    output matrix_pkg::dim_t    r_out,
    output matrix_pkg::dim_t    c_out,
    output matrix_pkg::matrix_t data_out,
    output logic                valid,
    output logic                busy
);
    import matrix_pkg::*;

    localparam logic [1:0] st_idle     = 2'd0;
    localparam logic [1:0] st_running  = 2'd1;
    localparam logic [1:0] st_done     = 2'd2;
    localparam logic [1:0] st_rejected = 2'd3;

    logic [1:0] state;
    logic       dims_ok;
    logic       clear;
    logic       start_order;
    logic       start_add;
    logic       start_restore;
    logic       grid_valid_a;
    logic       grid_valid_b;
    logic       grid_valid_q;
    logic       add_done;
    logic       restore_done;
    matrix_t    grid_a;
    matrix_t    grid_b;
    matrix_t    sum;
    matrix_t    restore_data;

    assign dims_ok = (r1 == r2) && (c1 == c2)
                  && (r1 >= 3'd1) && (r1 <= 3'(max_dim))
                  && (c1 >= 3'd1) && (c1 <= 3'(max_dim));

    // en low clears every stage on the same edge
    assign clear = ~en;

    // first cycle both grids are ready
    assign start_add     = grid_valid_a & grid_valid_b & ~grid_valid_q;
    assign start_restore = add_done;

    matrix_order order_a_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .clear      (clear),
        .start      (start_order),
        .rows       (r1),
        .cols       (c1),
        .data_in    (data1_in),
        .grid       (grid_a),
        .grid_valid (grid_valid_a)
    );

    matrix_order order_b_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .clear      (clear),
        .start      (start_order),
        .rows       (r2),
        .cols       (c2),
        .data_in    (data2_in),
        .grid       (grid_b),
        .grid_valid (grid_valid_b)
    );

    row_adder row_adder_i (
        .clk     (clk),
        .reset_n (reset_n),
        .clear   (clear),
        .start   (start_add),
        .grid_a  (grid_a),
        .grid_b  (grid_b),
        .sum     (sum),
        .done    (add_done)
    );

    matrix_restore restore_i (
        .clk      (clk),
        .reset_n  (reset_n),
        .clear    (clear),
        .start    (start_restore),
        .rows     (r_out),
        .cols     (c_out),
        .grid     (sum),
        .data_out (restore_data),
        .done     (restore_done)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            grid_valid_q <= 1'b0;
        end else begin
            grid_valid_q <= grid_valid_a & grid_valid_b;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= st_idle;
            start_order <= 1'b0;
            busy        <= 1'b0;
            valid       <= 1'b1;
            r_out       <= '0;
            c_out       <= '0;
            data_out    <= '0;
        end else if (!en) begin
            // abort or release returns to idle
            state       <= st_idle;
            start_order <= 1'b0;
            busy        <= 1'b0;
            valid       <= 1'b1;
            r_out       <= '0;
            c_out       <= '0;
            data_out    <= '0;
        end else begin
            start_order <= 1'b0;
            case (state)
                st_idle: begin
                    if (dims_ok) begin
                        start_order <= 1'b1;
                        busy        <= 1'b1;
                        r_out       <= r1;
                        c_out       <= c1;
                        state       <= st_running;
                    end else begin
                        valid <= 1'b0;
                        state <= st_rejected;
                    end
                end
                st_running: begin
                    if (restore_done) begin
                        data_out <= restore_data;
                        busy     <= 1'b0;
                        state    <= st_done;
                    end
                end
                // hold result or rejection until en drops
                default: begin
                    state <= state;
                end
            endcase
        end
    end

    a_reject_not_busy: assert property (
        @(posedge clk) disable iff (!reset_n)
        !valid |-> !busy
    );

endmodule

/* rtl/matrix_restore.sv */
`timescale 1ns/1ps

module matrix_restore (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                clear,
    input  logic                start,
    input  matrix_pkg::dim_t    rows,
    input  matrix_pkg::dim_t    cols,
    input  matrix_pkg::matrix_t grid,
    output matrix_pkg::matrix_t data_out,
    output logic                done
);
    import matrix_pkg::*;

    matrix_t gathered;
    logic    loaded;

    // grid slot r*5+c back to packed slot r*cols+c
    always_comb begin
        gathered = '0;
        for (int r = 0; r < max_dim; r++) begin
            for (int c = 0; c < max_dim; c++) begin
                logic [4:0] src;
                logic [4:0] dst;
                src = 5'(r * max_dim + c);
                dst = 5'(r) * 5'(cols) + 5'(c);
                if (3'(r) < rows && 3'(c) < cols) begin
                    gathered.elem[dst] = grid.elem[src];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            done   <= 1'b0;
            loaded <= 1'b0;
        end else if (clear) begin
            done   <= 1'b0;
            loaded <= 1'b0;
        end else begin
            done <= start;
            if (start) begin
                loaded <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !clear) begin
            data_out <= gathered;
        end
    end

    // one restore per operation
    a_single_start: assert property (
        @(posedge clk) disable iff (!reset_n)
        start |-> !loaded
    );

endmodule

/* rtl/row_adder.sv */
`timescale 1ns/1ps

module row_adder (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                clear,
    input  logic                start,
    input  matrix_pkg::matrix_t grid_a,
    input  matrix_pkg::matrix_t grid_b,
    output matrix_pkg::matrix_t sum,
    output logic                done
);
    import matrix_pkg::*;

    logic [2:0] row_cnt;
    logic       active;
    logic       running;

    elem_t [max_dim-1:0] a_row;
    elem_t [max_dim-1:0] b_row;
    elem_t [max_dim-1:0] row_sum;

    // start itself already adds row 0
    assign running = start | active;

    assign a_row = grid_a.row[row_cnt];
    assign b_row = grid_b.row[row_cnt];

    // five parallel adders wrapping mod 512
    always_comb begin
        for (int c = 0; c < max_dim; c++) begin
            row_sum[c] = a_row[c] + b_row[c];
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            row_cnt <= 3'd0;
            active  <= 1'b0;
            done    <= 1'b0;
        end else if (clear) begin
            row_cnt <= 3'd0;
            active  <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            if (running) begin
                if (row_cnt == 3'(max_dim - 1)) begin
                    // last row written this edge
                    row_cnt <= 3'd0;
                    active  <= 1'b0;
                    done    <= 1'b1;
                end else begin
                    row_cnt <= row_cnt + 3'd1;
                    active  <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (running && !clear) begin
            sum.row[row_cnt] <= row_sum;
        end
    end

    a_row_cnt_range: assert property (
        @(posedge clk) disable iff (!reset_n)
        row_cnt <= 3'(max_dim - 1)
    );

endmodule

/* rtl/matrix_order.sv */
`timescale 1ns/1ps

module matrix_order (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                clear,
    input  logic                start,
    input  matrix_pkg::dim_t    rows,
    input  matrix_pkg::dim_t    cols,
    input  matrix_pkg::matrix_t data_in,
    output matrix_pkg::matrix_t grid,
    output logic                grid_valid
);
    import matrix_pkg::*;

    matrix_t scattered;

    // packed slot r*cols+c lands in grid slot r*5+c
    always_comb begin
        scattered = '0;
        for (int r = 0; r < max_dim; r++) begin
            for (int c = 0; c < max_dim; c++) begin
                logic [4:0] src;
                logic [4:0] dst;
                src = 5'(r) * 5'(cols) + 5'(c);
                dst = 5'(r * max_dim + c);
                if (3'(r) < rows && 3'(c) < cols) begin
                    scattered.elem[dst] = data_in.elem[src];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            grid_valid <= 1'b0;
        end else if (clear) begin
            grid_valid <= 1'b0;
        end else if (start) begin
            grid_valid <= 1'b1;
        end
    end

    // grid captured once per operation
    always_ff @(posedge clk) begin
        if (start && !clear) begin
            grid <= scattered;
        end
    end

    a_dims_legal: assert property (
        @(posedge clk) disable iff (!reset_n)
        start |-> (rows >= 3'd1 && rows <= 3'(max_dim) && cols >= 3'd1 && cols <= 3'(max_dim))
    );

endmodule

/* rtl/matrix_pkg.sv */
package matrix_pkg;

    localparam int data_width = 9;
    localparam int max_dim = 5;
    localparam int grid_size = max_dim * max_dim;

    typedef logic [data_width-1:0] elem_t;

    // row or column count legal in 1..5
    typedef logic [2:0] dim_t;

    // one 225-bit word read by slot or by grid row
    typedef union packed {
        elem_t [grid_size-1:0] elem;
        elem_t [max_dim-1:0][max_dim-1:0] row;
    } matrix_t;

endpackage
